// ==== src/sdramCtrl_settings.svh ====
`ifndef SDRAMCTRL_SETTINGS_SVH
`define SDRAMCTRL_SETTINGS_SVH

// Device geometry.
`define SDRAM_DQ_W    16  // Data bus width.
`define SDRAM_ROW_W   13  // Row address, also the A bus width.
`define SDRAM_COL_W   9   // Column address.
`define SDRAM_BANK_W  2   // Bank select.
`define SDRAM_ADDR_W  24  // Bank + row + column.
`define SDRAM_LANES   4   // Longest burst, one lane per beat.

// Timing in clock cycles.
`define SDRAM_T_RP    3   // Precharge period.
`define SDRAM_T_RRC   9   // Auto-refresh cycle.
`define SDRAM_T_RCD   3   // ACT to column command.
`define SDRAM_T_MRD   2   // Mode register set.
`define SDRAM_T_WR    2   // Write recovery.
`define SDRAM_CL      3   // CAS latency.
`define SDRAM_T_INIT  20  // Power-up wait, short for simulation.
`define SDRAM_CNT_W   8   // Shared timing counter.

`define APB_ADDR_W    5

`endif

// ==== src/sdramCmdPkg.sv ====
package sdramCmdPkg;

    // Pin command as {cke, csN, rasN, casN, weN}.
    typedef enum logic [4:0] {
        INIT = 5'b01111,  // Clock disabled, power-up.
        NOP  = 5'b10111,
        ACT  = 5'b10011,  // Open bank and row.
        WR   = 5'b10100,
        RD   = 5'b10101,
        BST  = 5'b10110,  // Burst stop.
        PRE  = 5'b10010,  // A10 high closes all banks.
        AREF = 5'b10001,
        LMR  = 5'b10000   // Mode register on A bus.
    } sdramCmdE;

    typedef enum logic [3:0] {
        IDLE,
        WAIT_INIT,   // Power-up delay.
        PRECHARGE,
        REFRESH1,
        REFRESH2,
        LOAD_MODE,
        ACTIVATE,
        COLUMN,      // Read CAS latency wait.
        BURST,       // One beat per cycle.
        RECOVER,     // Auto-precharge time.
        DONE
    } seqStateE;

endpackage

// ==== src/sdramHostPkg.sv ====
`include "sdramCtrl_settings.svh"

package sdramHostPkg;

    // CTRL bits 1:0.
    typedef enum logic [1:0] {
        OP_INIT    = 2'd0,
        OP_REFRESH = 2'd1,
        OP_READ    = 2'd2,
        OP_WRITE   = 2'd3
    } sdramOpE;

    // APB byte offsets.
    typedef enum logic [`APB_ADDR_W-1:0] {
        REG_CTRL   = 5'h00,  // Opcode, four-word bit.
        REG_ADDR   = 5'h04,
        REG_STATUS = 5'h08,  // Busy, done, initialised.
        REG_DATA0  = 5'h10,
        REG_DATA1  = 5'h14,
        REG_DATA2  = 5'h18,
        REG_DATA3  = 5'h1C
    } apbRegE;

endpackage

// ==== src/sdramApbRegs.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramApbRegs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     PSEL,
    input  logic                     PENABLE,
    input  logic                     PWRITE,
    input  logic [`APB_ADDR_W-1:0]   PADDR,
    input  logic [31:0]              PWDATA,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     initDone,
    input  logic [`SDRAM_DQ_W-1:0]   laneRdWords [`SDRAM_LANES],
    output logic [31:0]              PRDATA,
    output logic                     PSLVERR,
    output logic                     start,
    output sdramHostPkg::sdramOpE    op,
    output logic                     fourWord,
    output logic [`SDRAM_ADDR_W-1:0] addr,
    output logic                     wrEn,
    output logic [1:0]               wrLane,
    output logic [`SDRAM_DQ_W-1:0]   wrWord
);
    import sdramHostPkg::*;

    logic        access;
    logic        mapped;
    logic        ctrlWr;
    logic        blocked;
    logic        launch;
    logic        doneSticky;
    logic [31:0] rdData;

    assign access  = PSEL && PENABLE;  // APB access phase.
    assign ctrlWr  = access && PWRITE && (PADDR == REG_CTRL);
    assign blocked = busy || start;    // Start still in flight.
    assign launch  = ctrlWr && !blocked;

    ////////////////////////////////////////
    // Offset decode and read mux
    ////////////////////////////////////////
    always_comb begin
        mapped = 1'b1;
        rdData = '0;
        case (apbRegE'(PADDR))
            REG_CTRL:   rdData = '0;  // Write only.
            REG_ADDR:   rdData = 32'(addr);
            REG_STATUS: rdData = {29'd0, initDone, doneSticky, busy};
            REG_DATA0, REG_DATA1, REG_DATA2, REG_DATA3:
                rdData = 32'(laneRdWords[PADDR[3:2]]);
            default:    mapped = 1'b0;
        endcase
    end

    assign PRDATA  = (access && !PWRITE && mapped) ? rdData : '0;
    assign PSLVERR = access && (!mapped || (ctrlWr && blocked));

    // Data register writes go straight to the lanes.
    assign wrEn   = access && PWRITE && mapped && PADDR[4];
    assign wrLane = PADDR[3:2];
    assign wrWord = PWDATA[`SDRAM_DQ_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start      <= 1'b0;
            op         <= OP_INIT;
            fourWord   <= 1'b0;
            addr       <= '0;
            doneSticky <= 1'b0;
        end else begin
            start <= launch;  // One-cycle pulse.
            if (launch) begin
                op         <= sdramOpE'(PWDATA[1:0]);
                fourWord   <= PWDATA[2];
                doneSticky <= 1'b0;  // New operation pending.
            end else if (done) begin
                doneSticky <= 1'b1;
            end
            if (access && PWRITE && (PADDR == REG_ADDR)) begin
                addr <= PWDATA[`SDRAM_ADDR_W-1:0];
            end
        end
    end

    // Access phase always follows a setup phase.
    aApbSetup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(PENABLE) |-> $past(PSEL));

endmodule

// ==== src/sdramDataLane.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramDataLane #(
    parameter int LANE_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wrEn,
    input  logic [1:0]             wrLane,
    input  logic [`SDRAM_DQ_W-1:0] wrWord,
    input  logic                   beatCapture,
    input  logic [1:0]             beatIdx,
    input  logic [`SDRAM_DQ_W-1:0] dqIn,
    output logic [`SDRAM_DQ_W-1:0] txWord,
    output logic [`SDRAM_DQ_W-1:0] rdWord
);
    localparam logic [1:0] MyIdx = 2'(LANE_ID);  // Beat slot of this lane.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txWord <= '0;
            rdWord <= '0;
        end else begin
            if (wrEn && (wrLane == MyIdx)) begin
                txWord <= wrWord;  // Host write word.
            end
            if (beatCapture && (beatIdx == MyIdx)) begin
                rdWord <= dqIn;    // Our read beat.
            end
        end
    end

endmodule

// ==== src/sdramSequencer.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramSequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  sdramHostPkg::sdramOpE    op,
    input  logic                     fourWord,
    input  logic [`SDRAM_ADDR_W-1:0] addr,
    input  logic [`SDRAM_DQ_W-1:0]   txWords [`SDRAM_LANES],
    output logic                     busy,
    output logic                     done,
    output logic                     initDone,
    output logic                     beatValid,
    output logic                     beatCapture,
    output logic [1:0]               beatIdx,
    output logic                     cke,
    output logic                     csN,
    output logic                     rasN,
    output logic                     casN,
    output logic                     weN,
    output logic [`SDRAM_BANK_W-1:0] ba,
    output logic [`SDRAM_ROW_W-1:0]  a,
    output logic [1:0]               dqm,
    output logic [`SDRAM_DQ_W-1:0]   dqOut,
    output logic                     dqOe
);
    import sdramCmdPkg::*;
    import sdramHostPkg::*;

    // Last count of each timed state.
    localparam logic [`SDRAM_CNT_W-1:0] InitEnd  = `SDRAM_CNT_W'(`SDRAM_T_INIT - 1);
    localparam logic [`SDRAM_CNT_W-1:0] RpEnd    = `SDRAM_CNT_W'(`SDRAM_T_RP - 1);
    localparam logic [`SDRAM_CNT_W-1:0] RrcEnd   = `SDRAM_CNT_W'(`SDRAM_T_RRC - 1);
    localparam logic [`SDRAM_CNT_W-1:0] MrdEnd   = `SDRAM_CNT_W'(`SDRAM_T_MRD - 1);
    localparam logic [`SDRAM_CNT_W-1:0] RcdEnd   = `SDRAM_CNT_W'(`SDRAM_T_RCD - 1);
    localparam logic [`SDRAM_CNT_W-1:0] ClEnd    = `SDRAM_CNT_W'(`SDRAM_CL - 1);
    localparam logic [`SDRAM_CNT_W-1:0] WrRecEnd =
        `SDRAM_CNT_W'(`SDRAM_T_WR + `SDRAM_T_RP - 1);

    seqStateE                 state;
    sdramCmdE                 cmd;
    logic [`SDRAM_CNT_W-1:0]  cnt;
    logic [`SDRAM_ADDR_W-1:0] addrQ;
    logic                     burstFour;  // Programmed burst length.
    logic                     lastBeat;
    logic [`SDRAM_ROW_W-1:0]  colWord;
    logic [`SDRAM_ROW_W-1:0]  modeWord;

    assign {cke, csN, rasN, casN, weN} = cmd;
    assign dqm  = 2'b00;  // No byte masking.
    assign busy = (state != IDLE) && (state != DONE);
    assign done = (state == DONE);

    assign lastBeat = (beatIdx == 2'(burstFour ? `SDRAM_LANES - 1 : 0));
    // A10 set for auto-precharge, just above A9.
    assign colWord  = {{(`SDRAM_ROW_W - `SDRAM_COL_W - 2){1'b0}}, 1'b1, 1'b0,
                       addrQ[`SDRAM_COL_W-1:0]};
    // CL 3, sequential, burst write, BL 1 or 4.
    assign modeWord = {{(`SDRAM_ROW_W - 7){1'b0}}, 3'b011, 1'b0,
                       fourWord ? 3'b010 : 3'b000};

    ////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            cmd         <= NOP;
            cnt         <= '0;
            addrQ       <= '0;
            burstFour   <= 1'b0;
            initDone    <= 1'b0;
            beatValid   <= 1'b0;
            beatCapture <= 1'b0;
            beatIdx     <= '0;
            ba          <= '0;
            a           <= '0;
            dqOut       <= '0;
            dqOe        <= 1'b0;
        end else begin
            cmd <= NOP;  // Commands last one cycle.
            cnt <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        addrQ <= addr;
                        if (op == OP_INIT) begin
                            state <= WAIT_INIT;
                        end else if (op == OP_REFRESH) begin
                            state <= PRECHARGE;
                            cmd   <= PRE;
                            ba    <= '1;
                            a     <= '1;  // All banks.
                        end else begin
                            state <= ACTIVATE;
                            cmd   <= ACT;
                            ba    <= addr[`SDRAM_ADDR_W-1 -: `SDRAM_BANK_W];
                            a     <= addr[`SDRAM_COL_W +: `SDRAM_ROW_W];  // Row.
                        end
                    end
                end
                WAIT_INIT: if (cnt == InitEnd) begin
                    state <= PRECHARGE;
                    cnt   <= '0;
                    cmd   <= PRE;
                    ba    <= '1;
                    a     <= '1;
                end
                PRECHARGE: if (cnt == RpEnd) begin
                    state <= REFRESH1;
                    cnt   <= '0;
                    cmd   <= AREF;
                end
                REFRESH1: if (cnt == RrcEnd) begin
                    state <= REFRESH2;
                    cnt   <= '0;
                    cmd   <= AREF;
                end
                REFRESH2: if (cnt == RrcEnd) begin
                    cnt <= '0;
                    if (op == OP_INIT) begin
                        state     <= LOAD_MODE;
                        cmd       <= LMR;
                        ba        <= '0;
                        a         <= modeWord;
                        burstFour <= fourWord;
                    end else begin
                        state <= DONE;
                    end
                end
                LOAD_MODE: if (cnt == MrdEnd) begin
                    state    <= DONE;
                    initDone <= 1'b1;
                end
                ACTIVATE: if (cnt == RcdEnd) begin
                    cnt       <= '0;
                    ba        <= addrQ[`SDRAM_ADDR_W-1 -: `SDRAM_BANK_W];
                    a         <= colWord;
                    beatValid <= (op == OP_WRITE);
                    beatIdx   <= '0;
                    if (op == OP_WRITE) begin
                        state <= BURST;  // WR carries beat 0.
                        cmd   <= WR;
                        dqOut <= txWords[0];
                        dqOe  <= 1'b1;
                    end else begin
                        state <= COLUMN;
                        cmd   <= RD;
                    end
                end
                COLUMN: if (cnt == ClEnd) begin
                    state       <= BURST;  // Beat 0 on dqIn next cycle.
                    beatValid   <= 1'b1;
                    beatCapture <= 1'b1;
                end
                BURST: begin
                    cnt <= '0;
                    if (lastBeat) begin
                        state       <= RECOVER;
                        beatValid   <= 1'b0;
                        beatCapture <= 1'b0;
                        dqOe        <= 1'b0;
                    end else begin
                        beatIdx <= beatIdx + 2'd1;
                        dqOut   <= txWords[beatIdx + 2'd1];
                    end
                end
                RECOVER: if (cnt == ((op == OP_WRITE) ? WrRecEnd : RpEnd)) begin
                    state <= DONE;
                end
                default: state <= IDLE;  // DONE lasts one cycle.
            endcase
        end
    end

    // Column commands always carry auto-precharge.
    aAutoPre: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == WR || cmd == RD) |-> a[10]);
    // Bus driven only while write data is valid.
    aDqOeWrite: assert property (@(posedge clk) disable iff (!rst_n)
        dqOe |-> beatValid && !beatCapture && (op == OP_WRITE));
    aStartIdle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

// ==== src/sdramCtrlTop.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramCtrlTop (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     PSEL,
    input  logic                     PENABLE,
    input  logic                     PWRITE,
    input  logic [`APB_ADDR_W-1:0]   PADDR,
    input  logic [31:0]              PWDATA,
    output logic [31:0]              PRDATA,
    output logic                     PSLVERR,
    output logic                     cke,
    output logic                     csN,
    output logic                     rasN,
    output logic                     casN,
    output logic                     weN,
    output logic [`SDRAM_BANK_W-1:0] ba,
    output logic [`SDRAM_ROW_W-1:0]  a,
    output logic [1:0]               dqm,
    output logic [`SDRAM_DQ_W-1:0]   dqOut,
    output logic                     dqOe,   // Pad ring tristate enable.
    input  logic [`SDRAM_DQ_W-1:0]   dqIn
);
    import sdramHostPkg::*;

    sdramOpE                  op;
    logic                     start;
    logic                     fourWord;
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic                     busy;
    logic                     done;
    logic                     initDone;
    logic                     wrEn;
    logic [1:0]               wrLane;
    logic [`SDRAM_DQ_W-1:0]   wrWord;
    logic                     beatCapture;
    logic [1:0]               beatIdx;
    logic [`SDRAM_DQ_W-1:0]   txWords [`SDRAM_LANES];  // Lane write words.
    logic [`SDRAM_DQ_W-1:0]   rdWords [`SDRAM_LANES];  // Lane read words.

    sdramApbRegs u_regs (
        .clk, .rst_n,
        .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PSLVERR,
        .busy, .done, .initDone,
        .laneRdWords (rdWords),
        .start, .op, .fourWord, .addr,
        .wrEn, .wrLane, .wrWord
    );

    for (genvar k = 0; k < `SDRAM_LANES; k++) begin : gLane
        sdramDataLane #(.LANE_ID(k)) u_lane (
            .clk, .rst_n,
            .wrEn, .wrLane, .wrWord,
            .beatCapture, .beatIdx, .dqIn,
            .txWord (txWords[k]),
            .rdWord (rdWords[k])
        );
    end

    sdramSequencer u_seq (
        .clk, .rst_n,
        .start, .op, .fourWord, .addr, .txWords,
        .busy, .done, .initDone,
        .beatValid (), .beatCapture, .beatIdx,
        .cke, .csN, .rasN, .casN, .weN,
        .ba, .a, .dqm, .dqOut, .dqOe
    );

endmodule

// ==== test/sdramModel.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramModel (
    input  logic                     clk,
    input  logic                     cke,
    input  logic                     csN,
    input  logic                     rasN,
    input  logic                     casN,
    input  logic                     weN,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_DQ_W-1:0]   dqOut,
    input  logic                     dqOe,
    output logic [`SDRAM_DQ_W-1:0]   dqIn
);
    import sdramCmdPkg::*;

    logic [`SDRAM_DQ_W-1:0]  mem [int];      // Keyed by {bank, row, col}.
    logic [`SDRAM_ROW_W-1:0] openRow [4];
    logic [4:0]              cmdLog [0:255]; // Non-NOP commands in order.
    int                      logCount = 0;
    logic [`SDRAM_ROW_W-1:0] lmrA = '0;      // Last mode word.
    logic                    burstFour = 1'b0;
    logic [4:0]              cmdNow;
    logic [`SDRAM_BANK_W-1:0] curBank;
    logic [`SDRAM_COL_W-1:0]  curCol;
    int                      wrLeft = 0;
    int                      wrBeat = 0;
    int                      rdLeft = 0;
    int                      rdBeat = 0;
    int                      rdDelay = 0;

    assign cmdNow = {cke, csN, rasN, casN, weN};

    function automatic int wordKey(input int beat);
        return int'({curBank, openRow[curBank], `SDRAM_COL_W'(curCol + beat)});
    endfunction

    // Testbench back door into the array.
    function automatic logic [`SDRAM_DQ_W-1:0] peekWord(input logic [`SDRAM_ADDR_W-1:0] addr);
        if (mem.exists(int'(addr))) return mem[int'(addr)];
        return 'x;
    endfunction

    initial dqIn = '0;

    always @(posedge clk) begin
        // Burst continuation first.
        if (wrLeft > 0 && dqOe) begin
            mem[wordKey(wrBeat)] = dqOut;
            wrBeat++;
            wrLeft--;
        end
        if (rdDelay > 0) begin
            rdDelay--;
        end else if (rdLeft > 0) begin
            dqIn <= mem.exists(wordKey(rdBeat)) ? mem[wordKey(rdBeat)] : '0;
            rdBeat++;
            rdLeft--;
        end
        if (!csN && cmdNow != NOP) begin
            cmdLog[logCount[7:0]] = cmdNow;
            logCount++;
            case (sdramCmdE'(cmdNow))
                ACT: openRow[ba] = a;
                WR: begin
                    curBank = ba;
                    curCol  = a[`SDRAM_COL_W-1:0];
                    mem[wordKey(0)] = dqOut;  // Beat 0 rides with WR.
                    wrBeat = 1;
                    wrLeft = burstFour ? `SDRAM_LANES - 1 : 0;
                end
                RD: begin
                    curBank = ba;
                    curCol  = a[`SDRAM_COL_W-1:0];
                    rdDelay = `SDRAM_CL - 2;  // Data valid CL edges after RD.
                    rdBeat  = 0;
                    rdLeft  = burstFour ? `SDRAM_LANES : 1;
                end
                LMR: begin
                    lmrA      = a;
                    burstFour = (a[2:0] == 3'b010);
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== test/sdramCtrlTb.sv ====
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"

module sdramCtrlTb;
    import sdramHostPkg::*;
    import sdramCmdPkg::*;

    localparam int NumVec   = 9;
    localparam int OpCycles = `SDRAM_T_INIT + 40;  // Longest operation.
    localparam int Limit    = NumVec * (2 * OpCycles + 120) + 100;

    logic clk, rst_n, PSEL, PENABLE, PWRITE, PSLVERR;
    logic [`APB_ADDR_W-1:0] PADDR;
    logic [31:0] PWDATA, PRDATA;
    logic cke, csN, rasN, casN, weN, dqOe;
    logic [`SDRAM_BANK_W-1:0] ba;
    logic [`SDRAM_ROW_W-1:0] a;
    logic [1:0] dqm;
    logic [`SDRAM_DQ_W-1:0] dqOut, dqIn;
    logic [159:0] vecs [0:NumVec-1];  // kind, flag, addr, w0..w3, e0..e3.
    int valueErrs = 0;
    int otherErrs = 0;
    int cycles = 0;

    sdramCtrlTop u_dut (.*);
    sdramModel u_mem (.clk, .cke, .csN, .rasN, .casN, .weN, .ba, .a, .dqOut, .dqOe, .dqIn);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycle budget for the whole run.
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= Limit) begin
                $display("Timeout: run did not finish within %0d cycles", Limit);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            valueErrs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic apbXfer(input logic wr, input logic [4:0] addr, input logic [31:0] data,
                           output logic [31:0] rd, output logic err);
        @(posedge clk); #1;
        PSEL   = 1'b1;  // Setup phase.
        PWRITE = wr;
        PADDR  = addr;
        PWDATA = data;
        @(posedge clk); #1;
        PENABLE = 1'b1;
        @(negedge clk);
        rd  = PRDATA;
        err = PSLVERR;
        @(posedge clk); #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apbXfer(1'b1, addr, data, rd, err);
        assert (!err) else begin
            otherErrs++;
            $display("APB write to offset %h was refused unexpectedly", addr);
        end
    endtask

    task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
        logic err;
        apbXfer(1'b0, addr, 32'd0, data, err);
        assert (!err) else begin
            otherErrs++;
            $display("APB read from offset %h was refused unexpectedly", addr);
        end
    endtask

    task automatic waitDone();
        logic [31:0] s;
        do readReg(REG_STATUS, s); while (s[0] || !s[1]);  // Not busy, done seen.
    endtask

    task automatic runOp(input sdramOpE op, input logic four);
        writeReg(REG_CTRL, {29'd0, four, op});
        waitDone();
    endtask

    function automatic logic [15:0] field(input logic [159:0] v, input int base, input int i);
        return v[base - 16 * i -: 16];
    endfunction

    task automatic loadWrite(input logic [159:0] v);
        writeReg(REG_ADDR, 32'(v[151:128]));
        for (int i = 0; i < 4; i++) writeReg(5'(REG_DATA0 + 4 * i), 32'(field(v, 127, i)));
    endtask

    task automatic checkMem(input int n, input logic [159:0] v);
        for (int i = 0; i < (v[152] ? 4 : 1); i++)  // Column plus beat.
            checkValue($sformatf("vec%0d mem+%0d", n, i), 32'(field(v, 127, i)),
                       32'(u_mem.peekWord(v[151:128] + 24'(i))));
    endtask

    task automatic readCheck(input int n, input logic [159:0] v);
        logic [31:0] d;
        writeReg(REG_ADDR, 32'(v[151:128]));
        runOp(OP_READ, v[152]);
        for (int i = 0; i < 4; i++) begin
            readReg(5'(REG_DATA0 + 4 * i), d);
            checkValue($sformatf("vec%0d DATA%0d", n, i), 32'(field(v, 63, i)), d);
        end
    endtask

    task automatic checkLog(input int n, input int base, input int len);
        checkValue($sformatf("vec%0d log length", n), 32'(len), 32'(u_mem.logCount - base));
        checkValue($sformatf("vec%0d log PRE", n), 32'(PRE), 32'(u_mem.cmdLog[base]));
        checkValue($sformatf("vec%0d log AREF1", n), 32'(AREF), 32'(u_mem.cmdLog[base + 1]));
        checkValue($sformatf("vec%0d log AREF2", n), 32'(AREF), 32'(u_mem.cmdLog[base + 2]));
    endtask

    initial begin
        logic [159:0] v;
        logic [31:0] d;
        logic err;
        int base;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        rst_n = 1'b0;
        $readmemh("test/sdramCtrl_vectors.txt", vecs);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        checkValue("reset pins", 32'(NOP), 32'({cke, csN, rasN, casN, weN}));
        checkValue("reset dqOe", 32'd0, 32'(dqOe));
        checkValue("reset dqm", 32'd0, 32'(dqm));
        readReg(REG_STATUS, d);
        checkValue("reset STATUS", 32'd0, d);

        ////////////////////////////////////////
        // Vector replay
        for (int n = 0; n < NumVec; n++) begin
            v = vecs[n];
            base = u_mem.logCount;
            case (v[159:156])
                4'd0: begin  // Init, flag is four-word mode.
                    runOp(OP_INIT, v[152]);
                    checkLog(n, base, 4);
                    checkValue($sformatf("vec%0d log LMR", n), 32'(LMR),
                               32'(u_mem.cmdLog[base + 3]));
                    checkValue($sformatf("vec%0d LMR 6:4", n), 32'h3, 32'(u_mem.lmrA[6:4]));
                    checkValue($sformatf("vec%0d LMR 2:0", n), v[152] ? 32'h2 : 32'h0,
                               32'(u_mem.lmrA[2:0]));
                    readReg(REG_STATUS, d);
                    checkValue($sformatf("vec%0d STATUS", n), 32'h6, d);
                end
                4'd1: begin  // Refresh then read back.
                    runOp(OP_REFRESH, v[152]);
                    checkLog(n, base, 3);
                    readCheck(n, v);
                end
                4'd2: begin  // Write then read.
                    loadWrite(v);
                    runOp(OP_WRITE, v[152]);
                    checkMem(n, v);
                    readCheck(n, v);
                end
                default: begin  // Second CTRL write lands while busy.
                    loadWrite(v);
                    writeReg(REG_CTRL, {29'd0, v[152], OP_WRITE});
                    apbXfer(1'b1, REG_CTRL, {29'd0, v[152], OP_READ}, d, err);
                    assert (err) else begin
                        otherErrs++;
                        $display("CTRL write while busy was not refused in vector %0d", n);
                    end
                    waitDone();
                    checkMem(n, v);
                    readCheck(n, v);
                end
            endcase
        end

        $display("Summary: %0d value errors, %0d other errors", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/sdramCtrl_vectors.txt ====
// kind_flag_addr_w0_w1_w2_w3_e0_e1_e2_e3
// kind 0 init, 1 refresh+read, 2 write+read, 3 busy refusal; flag 1 = four-word
0_1_000000_0000_0000_0000_0000_0000_0000_0000_0000
2_1_000000_A0A0_A1A1_A2A2_A3A3_A0A0_A1A1_A2A2_A3A3
2_1_C12348_1234_5678_9ABC_DEF0_1234_5678_9ABC_DEF0
2_1_5A0F10_0F0F_F0F0_3C3C_C3C3_0F0F_F0F0_3C3C_C3C3
1_1_000000_0000_0000_0000_0000_A0A0_A1A1_A2A2_A3A3
3_1_3FF1F0_CAFE_F00D_1357_2468_CAFE_F00D_1357_2468
0_0_000000_0000_0000_0000_0000_0000_0000_0000_0000
2_0_000104_BEEF_0000_0000_0000_BEEF_F00D_1357_2468
1_0_000104_0000_0000_0000_0000_BEEF_F00D_1357_2468

// ==== sdramCtrl.f ====
+incdir+src
src/sdramCmdPkg.sv
src/sdramHostPkg.sv
src/sdramApbRegs.sv
src/sdramDataLane.sv
src/sdramSequencer.sv
src/sdramCtrlTop.sv
test/sdramModel.sv
test/sdramCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sdramCtrl.f --top-module sdramCtrlTb \
    -Mdir build -o simv \
    && ./build/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && exit 0 || exit 1
